//--- verilog/cpu_pkg.sv
/*
 * Widths, instruction fields and opcodes shared by the 16-bit sequencer.
 * Instruction word is 20 bits. imm8 overlaps rt, and the wait count overlaps rs, rt and imm8.
 * LDR (0x09), ST (0x0C) and 0x10..0x1E are not decoded and run as one-cycle NOPs.
 */
`default_nettype none

package cpu_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int DATA_W  = 16;   // Register and datapath
    localparam int REG_AW  = 3;    // Eight registers
    localparam int PC_W    = 8;    // 256-word program store
    localparam int INSTR_W = 20;
    localparam int WAIT_W  = 11;
    localparam int OPC_W   = 5;
    localparam int IMM_W   = 8;

    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;
    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [WAIT_W-1:0]  wait_t;
    typedef logic [OPC_W-1:0]   opcode_t;

    // Jump return address lands here
    localparam reg_addr_t LINK_REG = 3'd7;

    //////////////////////////////
    // Field positions (lsb)
    //////////////////////////////
    localparam int OPC_LSB  = 15;  // 19:15
    localparam int X_POS    = 14;
    localparam int RD_LSB   = 11;  // 13:11
    localparam int RS_LSB   = 8;   // 10:8
    localparam int RT_LSB   = 5;   // 7:5
    localparam int IMM_LSB  = 0;   // 7:0
    localparam int WAIT_LSB = 0;   // 10:0

    //////////////////////////////
    // Opcodes
    //////////////////////////////
    localparam opcode_t OP_AND  = 5'b00000;
    localparam opcode_t OP_OR   = 5'b00001;
    localparam opcode_t OP_XOR  = 5'b00010;
    localparam opcode_t OP_NOT  = 5'b00011;
    localparam opcode_t OP_ADD  = 5'b00100;  // x: rs + imm8
    localparam opcode_t OP_LSL  = 5'b00101;
    localparam opcode_t OP_SR   = 5'b00110;  // x: arithmetic
    localparam opcode_t OP_ROT  = 5'b00111;  // x: right
    localparam opcode_t OP_MOV  = 5'b01000;  // x: swap
    localparam opcode_t OP_LDU  = 5'b01010;
    localparam opcode_t OP_LDL  = 5'b01011;
    localparam opcode_t OP_J    = 5'b01101;  // x: imm8 target
    localparam opcode_t OP_B    = 5'b01110;  // x: on N, else on Z
    localparam opcode_t OP_NOP  = 5'b01111;  // Timed by wait count
    localparam opcode_t OP_HALT = 5'b11111;

    // Fetch sequencing
    typedef enum logic [1:0] {
        RUN,
        WAIT,
        HALTED
    } fetch_state_t;

endpackage

`default_nettype wire

//--- verilog/control_unit.sv
/*
 * Opcode decoder. Purely combinational, so every strobe follows the instruction word.
 * Strobes are not gated by the fetch state. The datapath ANDs write enables with exec_en.
 * Unimplemented opcodes leave every strobe low and are reported in simulation.
 */
`default_nettype none

module control_unit
    import cpu_pkg::*;
(
    input  opcode_t opcode,
    input  logic    x_bit,
    input  logic    timer_busy,
    output logic    alu_to_reg,    // Port 0 data from ALU
    output logic    pcr_to_reg,    // Port 1 data is pc+1
    output logic    src_to_reg,    // Port 0 data is rs
    output logic    reg_we_dst_0,
    output logic    reg_we_dst_1,
    output logic    add_immd,
    output logic    jump_immd,
    output logic    ldu,
    output logic    ldl,
    output logic    branch,
    output logic    jump,
    output logic    z_we,
    output logic    n_we,
    output logic    v_we,
    output logic    set_timer,
    output logic    halt
);

    logic known_op;  // Low on spare codes

    always_comb begin
        // Everything idles unless the opcode asks
        alu_to_reg   = 1'b0;
        pcr_to_reg   = 1'b0;
        src_to_reg   = 1'b0;
        reg_we_dst_0 = 1'b0;
        reg_we_dst_1 = 1'b0;
        add_immd     = 1'b0;
        jump_immd    = 1'b0;
        ldu          = 1'b0;
        ldl          = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        z_we         = 1'b0;
        n_we         = 1'b0;
        v_we         = 1'b0;
        set_timer    = 1'b0;
        halt         = 1'b0;
        known_op     = 1'b1;

        case (opcode)
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_LSL: begin
                alu_to_reg   = 1'b1;
                reg_we_dst_0 = 1'b1;
                z_we         = 1'b1;   // Logic and LSL touch Z only
            end
            OP_ADD: begin
                alu_to_reg   = 1'b1;
                reg_we_dst_0 = 1'b1;
                add_immd     = x_bit;
                z_we         = 1'b1;
                n_we         = 1'b1;
                v_we         = 1'b1;
            end
            OP_SR, OP_ROT: begin
                alu_to_reg   = 1'b1;   // Flags untouched
                reg_we_dst_0 = 1'b1;
            end
            OP_MOV: begin
                src_to_reg   = 1'b1;
                reg_we_dst_0 = 1'b1;
                reg_we_dst_1 = x_bit;  // Swap writes old rd back into rs
            end
            OP_LDU: begin
                reg_we_dst_0 = 1'b1;
                ldu          = 1'b1;
            end
            OP_LDL: begin
                reg_we_dst_0 = 1'b1;
                ldl          = 1'b1;
            end
            OP_J: begin
                jump         = 1'b1;
                jump_immd    = x_bit;
                pcr_to_reg   = 1'b1;   // Always links
                reg_we_dst_1 = 1'b1;
            end
            OP_B: begin
                branch = 1'b1;
            end
            OP_NOP: begin
                set_timer = ~timer_busy;   // No reload of a running count
            end
            OP_HALT: begin
                halt = 1'b1;
            end
            default: begin
                known_op = 1'b0;   // LDR, ST and vector codes
            end
        endcase
    end

    // Instruction word is X before the program is loaded
    always_comb begin
        if (!$isunknown(opcode)) begin
            spare_opcode: assert final (known_op)
                else $warning("control_unit: opcode %b not implemented, run as NOP", opcode);
        end
    end

endmodule

`default_nettype wire

//--- verilog/wait_timer.sv
/*
 * Down counter for timed NOPs. busy is high while the count is nonzero.
 * A load is ignored in the cycle in which the count has just reached zero,
 * so a timed NOP right behind a finished wait runs as a plain NOP.
 */
`default_nettype none

module wait_timer
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  set_timer,
    input  wait_t wait_count,
    output logic  busy
);

    wait_t count;
    logic  idle_q;     // Idle one cycle ago
    logic  expired;    // Count reached zero on the last edge

    assign busy    = (count != '0);
    assign expired = ~idle_q & ~busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            idle_q <= 1'b1;
        end else begin
            idle_q <= ~busy;
            if (set_timer && !expired)
                count <= wait_count;
            else if (busy)
                count <= count - 1'b1;
        end
    end

    // Decoder must hold off NOP loads until the count has drained
    no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        set_timer |-> !busy);

endmodule

`default_nettype wire

//--- verilog/fetch_fsm.sv
/*
 * Program counter and fetch sequencing. RUN executes one instruction per cycle.
 * WAIT follows the timer's busy output directly. HALTED lasts until reset.
 * The timed NOP itself retires in RUN and moves pc on. Instructions then stall while busy.
 */
`default_nettype none

module fetch_fsm
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             jump,
    input  logic             jump_immd,
    input  logic             branch,
    input  logic             x_bit,
    input  logic             halt,
    input  logic             set_timer,
    input  logic             timer_busy,
    input  logic             flag_z,
    input  logic             flag_n,
    input  logic [IMM_W-1:0] imm8,
    input  word_t            rs_value,
    output pc_t              pc,
    output logic             exec_en,
    output logic             halted
);

    fetch_state_t state_q;     // Registered part, RUN or HALTED
    fetch_state_t state;       // Seen by the datapath
    pc_t          pc_inc;
    pc_t          jump_target;
    pc_t          branch_target;
    pc_t          pc_next;
    logic         branch_taken;

    always_comb begin
        if (state_q == HALTED)
            state = HALTED;
        else if (timer_busy)
            state = WAIT;      // Exactly wait-count cycles
        else
            state = RUN;
    end

    assign exec_en = (state == RUN);
    assign halted  = (state_q == HALTED);

    //////////////////////////////
    // Next pc
    //////////////////////////////
    assign pc_inc        = pc + 1'b1;
    assign jump_target   = jump_immd ? pc_t'(imm8) : rs_value[PC_W-1:0];
    assign branch_target = pc_inc + pc_t'($signed(imm8));   // Relative to pc+1
    assign branch_taken  = branch & (x_bit ? flag_n : flag_z);

    always_comb begin
        pc_next = pc_inc;
        if (!exec_en || halt)
            pc_next = pc;              // Hold
        else if (jump)
            pc_next = jump_target;
        else if (branch_taken)
            pc_next = branch_target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RUN;
            pc      <= '0;
        end else begin
            pc <= pc_next;
            if (exec_en && halt)
                state_q <= HALTED;
        end
    end

    pc_frozen_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> $stable(pc));

    // Timer loads and pc steps past the NOP on the same edge
    nop_steps_once: assert property (@(posedge clk) disable iff (!rst_n)
        set_timer |=> (pc == $past(pc_inc)));

endmodule

`default_nettype wire

//--- verilog/prog_mem.sv
/*
 * 256-word instruction store. Written from outside, also while the core is in reset.
 * Read is combinational from the program counter. Contents are undefined until loaded.
 */
`default_nettype none

module prog_mem
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   load_we,
    input  pc_t    load_addr,
    input  instr_t load_data,
    input  pc_t    rd_addr,
    output instr_t instr
);

    instr_t mem [2**PC_W];   // One word per pc value

    // Load port, independent of reset
    always_ff @(posedge clk) begin
        if (load_we)
            mem[load_addr] <= load_data;
    end

    assign instr = mem[rd_addr];   // Same-cycle fetch

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
/*
 * Eight 16-bit registers, two async read and two sync write ports.
 * Port 1 wins when both ports write one address in the same cycle.
 */
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    input  logic      we0,
    input  reg_addr_t wa0,
    input  word_t     wd0,
    input  logic      we1,
    input  reg_addr_t wa1,
    input  word_t     wd1,
    output word_t     rd0,
    output word_t     rd1
);

    word_t regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else begin
            if (we0)
                regs[wa0] <= wd0;
            if (we1)
                regs[wa1] <= wd1;   // Later assignment, port 1 priority
        end
    end

    // No bypass, a write shows up the cycle after
    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

`default_nettype wire

//--- verilog/alu.sv
/*
 * ALU: logic ops, add with optional sign-extended imm8, one-place shifts and rotates.
 * Z, N and V are registered and change only on an enabled, executing instruction.
 * V is signed overflow of the add. N is the result sign bit.
 */
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  opcode_t          opcode,
    input  logic             x_bit,
    input  logic             add_immd,
    input  word_t            a,          // rs
    input  word_t            b,          // rt
    input  logic [IMM_W-1:0] imm8,
    input  logic             z_we,
    input  logic             n_we,
    input  logic             v_we,
    input  logic             exec_en,
    output word_t            result,
    output logic             flag_z,
    output logic             flag_n,
    output logic             flag_v
);

    word_t addend;
    word_t sum;
    logic  add_ovf;

    assign addend  = add_immd ? word_t'($signed(imm8)) : b;
    assign sum     = a + addend;
    // Same-sign operands, different-sign sum
    assign add_ovf = (a[DATA_W-1] == addend[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);

    always_comb begin
        case (opcode)
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_NOT:  result = ~a;
            OP_ADD:  result = sum;
            OP_LSL:  result = {a[DATA_W-2:0], 1'b0};
            OP_SR:   result = {x_bit & a[DATA_W-1], a[DATA_W-1:1]};   // x: keep sign
            OP_ROT:  result = x_bit ? {a[0], a[DATA_W-1:1]}           // ROR
                                    : {a[DATA_W-2:0], a[DATA_W-1]};  // ROL
            default: result = '0;   // Not an ALU op
        endcase
    end

    //////////////////////////////
    // Flag registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_z <= 1'b0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
        end else if (exec_en) begin
            if (z_we) flag_z <= (result == '0);
            if (n_we) flag_n <= result[DATA_W-1];
            if (v_we) flag_v <= add_ovf;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
/*
 * Single-cycle 16-bit sequencer. Load the program while rst_n is low, then release reset.
 * Runs from address 0 until HALT. wb_* mirrors register write port 0 as it is written.
 * Port 1 writes (swap, jump link) are not mirrored.
 */
`default_nettype none

module cpu_core
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_we,
    input  pc_t       load_addr,
    input  instr_t    load_data,
    output pc_t       pc,
    output logic      halted,
    output logic      wb_we,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    instr_t           instr;
    opcode_t          opcode;
    logic             x_bit;
    reg_addr_t        rd_field, rs_field, rt_field;
    logic [IMM_W-1:0] imm8;
    wait_t            wait_count;

    logic  alu_to_reg, pcr_to_reg, src_to_reg;
    logic  reg_we_dst_0, reg_we_dst_1;
    logic  add_immd, jump_immd, ldu, ldl, branch, jump;
    logic  z_we, n_we, v_we, set_timer, halt;
    logic  timer_busy, exec_en;
    logic  flag_z, flag_n;
    logic  swap;
    logic  we0, we1;
    reg_addr_t ra1, wa1;
    word_t rs_value, rd1_value, alu_result, wd0, wd1;
    pc_t   link_pc;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////
    assign opcode     = instr[OPC_LSB +: OPC_W];
    assign x_bit      = instr[X_POS];
    assign rd_field   = instr[RD_LSB +: REG_AW];
    assign rs_field   = instr[RS_LSB +: REG_AW];
    assign rt_field   = instr[RT_LSB +: REG_AW];
    assign imm8       = instr[IMM_LSB +: IMM_W];
    assign wait_count = instr[WAIT_LSB +: WAIT_W];

    prog_mem u_prog_mem (.clk, .load_we, .load_addr, .load_data, .rd_addr(pc), .instr);

    control_unit u_control_unit (
        .opcode, .x_bit, .timer_busy, .alu_to_reg, .pcr_to_reg, .src_to_reg,
        .reg_we_dst_0, .reg_we_dst_1, .add_immd, .jump_immd, .ldu, .ldl,
        .branch, .jump, .z_we, .n_we, .v_we, .set_timer, .halt
    );

    wait_timer u_wait_timer (.clk, .rst_n, .set_timer, .wait_count, .busy(timer_busy));

    fetch_fsm u_fetch_fsm (
        .clk, .rst_n, .jump, .jump_immd, .branch, .x_bit, .halt, .set_timer, .timer_busy,
        .flag_z, .flag_n, .imm8, .rs_value, .pc, .exec_en, .halted
    );

    //////////////////////////////
    // Register file and writeback
    //////////////////////////////
    assign swap    = src_to_reg & x_bit;
    assign ra1     = swap ? rd_field : rt_field;      // Swap needs old rd
    assign we0     = exec_en & reg_we_dst_0;          // No writes in WAIT/HALTED
    assign we1     = exec_en & reg_we_dst_1;
    assign link_pc = pc + 1'b1;
    assign wa1     = pcr_to_reg ? LINK_REG : rs_field;
    assign wd1     = pcr_to_reg ? word_t'(link_pc) : rd1_value;

    always_comb begin
        unique case (1'b1)
            alu_to_reg: wd0 = alu_result;
            src_to_reg: wd0 = rs_value;                               // MOV
            ldu:        wd0 = {imm8, rs_value[IMM_W-1:0]};           // New upper byte
            ldl:        wd0 = {rs_value[DATA_W-1:IMM_W], imm8};      // New lower byte
            default:    wd0 = '0;                                     // No port 0 write
        endcase
    end

    reg_file u_reg_file (
        .clk, .rst_n, .ra0(rs_field), .ra1, .we0, .wa0(rd_field), .wd0,
        .we1, .wa1, .wd1, .rd0(rs_value), .rd1(rd1_value)
    );

    // V is kept inside the ALU, nothing here consumes it
    alu u_alu (
        .clk, .rst_n, .opcode, .x_bit, .add_immd, .a(rs_value), .b(rd1_value), .imm8,
        .z_we, .n_we, .v_we, .exec_en, .result(alu_result), .flag_z, .flag_n, .flag_v()
    );

    assign wb_we   = we0;
    assign wb_addr = rd_field;
    assign wb_data = wd0;

endmodule

`default_nettype wire

//--- tb/tb_cpu_core.sv
/*
 * Directed testbench for cpu_core. Each test loads its program through the load port
 * during reset, runs it to HALT and checks the port 0 writeback sequence.
 * Expected writes and their cycles come from a small instruction-set model.
 * Cycle numbers count from the first cycle after reset release.
 */
`default_nettype none

module tb_cpu_core
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES  = 3;
    localparam int HALT_HOLD   = 20;
    localparam int WAIT_N      = 10;
    // Six programs under 20 words, their loads, one wait and the halt hold need < 300
    localparam int CYCLE_LIMIT = 2000;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      load_we;
    pc_t       load_addr;
    instr_t    load_data;
    pc_t       pc;
    logic      halted;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    instr_t    prog [$];        // Current program
    reg_addr_t exp_addr [$];
    word_t     exp_data [$];
    int        exp_cycle [$];
    reg_addr_t act_addr [$];
    word_t     act_data [$];
    int        act_cycle [$];
    pc_t       pc_log [$];      // pc of every cycle out of reset
    int        exp_halt_cycle;
    pc_t       exp_halt_pc;
    int        run_cycle = 0;
    int        total_cycles = 0;
    int        errors = 0;

    cpu_core UUT (.clk, .rst_n, .load_we, .load_addr, .load_data,
                  .pc, .halted, .wb_we, .wb_addr, .wb_data);

    always #20 clk = ~clk;   // 40 ns period

    // Watchdog
    always @(posedge clk) begin
        total_cycles <= total_cycles + 1;
        if (total_cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Writeback monitor, samples values settled before the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            run_cycle <= 0;
        end else begin
            run_cycle <= run_cycle + 1;
            pc_log.push_back(pc);
            if (wb_we) begin
                act_addr.push_back(wb_addr);
                act_data.push_back(wb_data);
                act_cycle.push_back(run_cycle);
            end
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic void report_mismatch(input string msg);
        errors++;
        $display("FAIL @%0t ns: %s", $time, msg);
    endfunction

    function automatic instr_t r_format(opcode_t op, logic x, reg_addr_t rd,
                                        reg_addr_t rs, reg_addr_t rt);
        return {op, x, rd, rs, rt, 5'b00000};
    endfunction

    function automatic instr_t i_format(opcode_t op, logic x, reg_addr_t rd,
                                        reg_addr_t rs, logic [7:0] imm);
        return {op, x, rd, rs, imm};
    endfunction

    // Instruction-set model, one step per instruction
    task automatic model_program();
        word_t      r [8];
        logic       z;
        logic       n;
        pc_t        p;
        int         cyc;
        instr_t     w;
        opcode_t    op;
        logic       x;
        reg_addr_t  rd;
        reg_addr_t  rs;
        logic [7:0] imm;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       wr;
        exp_addr.delete();
        exp_data.delete();
        exp_cycle.delete();
        r = '{default: '0};
        z = 1'b0;
        n = 1'b0;
        p = '0;
        cyc = 0;
        exp_halt_cycle = -1;
        while (exp_halt_cycle < 0) begin
            if (int'(p) >= prog.size() || cyc > CYCLE_LIMIT) begin
                $display("Model error: program ran past its end without HALT");
                errors++;
                break;
            end
            w   = prog[p];
            op  = w[19:15];
            x   = w[14];
            rd  = w[13:11];
            rs  = w[10:8];
            imm = w[7:0];
            a   = r[rs];
            b   = r[w[7:5]];
            res = '0;
            wr  = 1'b1;
            case (op)
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_NOT:  res = ~a;
                OP_ADD:  res = a + (x ? {{8{imm[7]}}, imm} : b);
                OP_LSL:  res = a << 1;
                OP_SR:   res = x ? word_t'($signed(a) >>> 1) : a >> 1;
                OP_ROT:  res = x ? (a >> 1) | (a << 15) : (a << 1) | (a >> 15);
                OP_MOV:  res = a;
                OP_LDU:  res = {imm, a[7:0]};
                OP_LDL:  res = {a[15:8], imm};
                default: wr = 1'b0;
            endcase
            if (op inside {OP_AND, OP_OR, OP_XOR, OP_NOT, OP_LSL, OP_ADD})
                z = (res == '0);
            if (op == OP_ADD)
                n = res[15];
            if (wr) begin
                exp_addr.push_back(rd);
                exp_data.push_back(res);
                exp_cycle.push_back(cyc);
                if (op == OP_MOV && x)
                    r[rs] = r[rd];     // Swap, old rd into rs
                r[rd] = res;
            end
            case (op)
                OP_J: begin
                    r[LINK_REG] = word_t'(p + 8'd1);
                    p = x ? imm : a[7:0];
                end
                OP_B:    p = (x ? n : z) ? p + 8'd1 + imm : p + 8'd1;
                OP_NOP: begin
                    cyc += int'(w[10:0]);   // Stall cycles
                    p = p + 8'd1;
                end
                OP_HALT: begin
                    exp_halt_cycle = cyc;
                    exp_halt_pc    = p;
                end
                default: p = p + 8'd1;
            endcase
            cyc++;
        end
    endtask

    task automatic compare_writes(input string name);
        int i;
        if (act_addr.size() != exp_addr.size())
            report_mismatch($sformatf("%s: %0d writes, expected %0d",
                                      name, act_addr.size(), exp_addr.size()));
        for (i = 0; i < exp_addr.size() && i < act_addr.size(); i++) begin
            if (act_addr[i] != exp_addr[i] || act_data[i] != exp_data[i] ||
                act_cycle[i] != exp_cycle[i])
                report_mismatch($sformatf(
                    "%s: write %0d r%0d=%h at cycle %0d, expected r%0d=%h at %0d",
                    name, i, act_addr[i], act_data[i], act_cycle[i],
                    exp_addr[i], exp_data[i], exp_cycle[i]));
        end
    endtask

    task automatic expect_write(input int idx, input reg_addr_t addr, input word_t data);
        if (idx >= act_addr.size())
            report_mismatch($sformatf("write %0d missing", idx));
        else if (act_addr[idx] != addr || act_data[idx] != data)
            report_mismatch($sformatf("write %0d r%0d=%h, expected r%0d=%h",
                                      idx, act_addr[idx], act_data[idx], addr, data));
    endtask

    // Load under reset, release, run to HALT
    task automatic run_program(input string name);
        int i;
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            load_we   <= 1'b1;
            load_addr <= pc_t'(i);
            load_data <= prog[i];
            @(posedge clk);
        end
        load_we <= 1'b0;
        for (i = prog.size(); i < RST_CYCLES; i++)
            @(posedge clk);
        act_addr.delete();
        act_data.delete();
        act_cycle.delete();
        pc_log.delete();
        rst_n <= 1'b1;
        while (!halted)
            @(posedge clk);
        if (run_cycle != exp_halt_cycle + 1)
            report_mismatch($sformatf("%s: halted seen in cycle %0d, expected %0d",
                                      name, run_cycle, exp_halt_cycle + 1));
        if (pc != exp_halt_pc)
            report_mismatch($sformatf("%s: pc %0d at halt, expected %0d", name, pc, exp_halt_pc));
        compare_writes(name);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic logic_and_add();
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h3C), i_format(OP_LDU, 1'b0, 3'd1, 3'd1, 8'hA5),
            i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'hF0), i_format(OP_LDU, 1'b0, 3'd2, 3'd2, 8'h0F),
            r_format(OP_AND, 1'b0, 3'd3, 3'd1, 3'd2),  r_format(OP_OR, 1'b0, 3'd4, 3'd1, 3'd2),
            r_format(OP_XOR, 1'b0, 3'd5, 3'd1, 3'd2),  r_format(OP_NOT, 1'b0, 3'd6, 3'd1, 3'd0),
            r_format(OP_ADD, 1'b0, 3'd3, 3'd1, 3'd2),  i_format(OP_ADD, 1'b1, 3'd4, 3'd1, 8'hFD),
            i_format(OP_ADD, 1'b1, 3'd5, 3'd5, 8'h7F), i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00)
        };
        model_program();
        run_program("logic/add");
    endtask

    task automatic shifts_and_rotates();
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h81), i_format(OP_LDU, 1'b0, 3'd1, 3'd1, 8'h96),
            r_format(OP_LSL, 1'b0, 3'd2, 3'd1, 3'd0),  r_format(OP_SR, 1'b0, 3'd3, 3'd1, 3'd0),
            r_format(OP_SR, 1'b1, 3'd4, 3'd1, 3'd0),   r_format(OP_ROT, 1'b0, 3'd5, 3'd1, 3'd0),
            r_format(OP_ROT, 1'b1, 3'd6, 3'd1, 3'd0),  r_format(OP_LSL, 1'b0, 3'd2, 3'd2, 3'd0),
            i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00)
        };
        model_program();
        run_program("shift/rotate");
    endtask

    task automatic moves_and_swap();
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h11), i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'h22),
            r_format(OP_MOV, 1'b0, 3'd3, 3'd1, 3'd0),  r_format(OP_MOV, 1'b1, 3'd1, 3'd2, 3'd0),
            r_format(OP_MOV, 1'b0, 3'd4, 3'd2, 3'd0),  r_format(OP_MOV, 1'b0, 3'd5, 3'd1, 3'd0),
            i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00)
        };
        model_program();
        run_program("move/swap");
        expect_write(3, 3'd1, 16'h0022);   // Swap writes rd on port 0
        expect_write(4, 3'd4, 16'h0011);   // rs now holds old rd
    endtask

    task automatic jumps_and_branches();
        int i;
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h05), i_format(OP_J, 1'b1, 3'd0, 3'd0, 8'd4),
            i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'hEE), i_format(OP_LDL, 1'b0, 3'd3, 3'd0, 8'hEE),
            r_format(OP_MOV, 1'b0, 3'd4, 3'd7, 3'd0),  r_format(OP_XOR, 1'b0, 3'd5, 3'd1, 3'd1),
            i_format(OP_B, 1'b0, 3'd0, 3'd0, 8'd1),    i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'hBB),
            i_format(OP_LDL, 1'b0, 3'd6, 3'd0, 8'h01), i_format(OP_B, 1'b1, 3'd0, 3'd0, 8'd1),
            i_format(OP_LDL, 1'b0, 3'd3, 3'd0, 8'h33), i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'h0E),
            i_format(OP_J, 1'b0, 3'd0, 3'd2, 8'd0),    i_format(OP_LDL, 1'b0, 3'd3, 3'd0, 8'hEE),
            r_format(OP_MOV, 1'b0, 3'd4, 3'd7, 3'd0),  i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00)
        };
        model_program();
        run_program("jump/branch");
        // Skipped words all load EE or BB
        for (i = 0; i < act_data.size(); i++) begin
            if (act_data[i][7:0] == 8'hEE || act_data[i][7:0] == 8'hBB)
                report_mismatch($sformatf("write %0d came from a skipped instruction", i));
        end
        expect_write(1, 3'd4, 16'd2);      // Link of the immediate jump
        expect_write(3, 3'd6, 16'h0001);   // BZ taken past pc 7
        expect_write(4, 3'd3, 16'h0033);   // BN not taken
        expect_write(6, 3'd4, 16'd13);     // Link of the register jump
    endtask

    task automatic timed_wait();
        int c;
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h01),
            i_format(OP_NOP, 1'b0, 3'd0, 3'd0, 8'(WAIT_N)),
            i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'h02),
            i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00)
        };
        model_program();
        run_program("timed wait");
        // NOP cycle plus WAIT_N stall cycles lie between the writes
        if (act_cycle.size() != 2)
            report_mismatch($sformatf("wait: %0d writes, expected 2", act_cycle.size()));
        else if (act_cycle[1] - act_cycle[0] != WAIT_N + 2)
            report_mismatch($sformatf("wait: writes %0d cycles apart, expected %0d",
                                      act_cycle[1] - act_cycle[0], WAIT_N + 2));
        for (c = 2; c <= WAIT_N + 2 && c < pc_log.size(); c++) begin
            if (pc_log[c] != 8'd2)
                report_mismatch($sformatf("wait: pc %0d in cycle %0d, expected 2", pc_log[c], c));
        end
    endtask

    task automatic halt_and_reset();
        int i;
        prog = '{
            i_format(OP_LDL, 1'b0, 3'd1, 3'd0, 8'h55), i_format(OP_HALT, 1'b0, 3'd0, 3'd0, 8'h00),
            i_format(OP_LDL, 1'b0, 3'd2, 3'd0, 8'h66)
        };
        model_program();
        run_program("halt");
        for (i = 0; i < HALT_HOLD; i++) begin
            @(posedge clk);
            if (!halted || pc != exp_halt_pc)
                report_mismatch($sformatf("halt: pc %0d, halted %0b while stopped", pc, halted));
            if (wb_we)
                report_mismatch("halt: register write after HALT");
        end
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        if (halted || pc != '0)
            report_mismatch($sformatf("reset: pc %0d, halted %0b, expected 0 and 0", pc, halted));
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rst_n     <= 1'b0;
        load_we   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        logic_and_add();
        shifts_and_rotates();
        moves_and_swap();
        jumps_and_branches();
        timed_wait();
        halt_and_reset();
        $display("Tests run: 6, errors: %0d", errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/wait_timer.sv
verilog/fetch_fsm.sv
verilog/prog_mem.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/cpu_core.sv
tb/tb_cpu_core.sv

//--- Makefile
# Verilator build for the 16-bit sequencer and its testbench

TOOL       = verilator
TOP        = tb_cpu_core
RTL_TOP    = cpu_core
FILELIST   = project.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
